// ==== Bender.yml ====
package:
  name: ooo_dispatch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ooo_pkg.sv
      - hdl/exec_unit.sv
      - hdl/operand_file.sv
      - hdl/rs_array.sv
      - hdl/issue_ctrl.sv
      - hdl/dispatch_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_dispatch.sv

// ==== compile.f ====
+incdir+hdl
hdl/ooo_pkg.sv
hdl/exec_unit.sv
hdl/operand_file.sv
hdl/rs_array.sv
hdl/issue_ctrl.sv
hdl/dispatch_top.sv
sim/tb_dispatch.sv

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module dispatch_top (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic [`OOO_DISP_W-1:0]  disp_valid_i,
	input  ooo_pkg::pc_t            disp_pc_i     [`OOO_DISP_W],
	input  ooo_pkg::opcode_t        disp_opcode_i [`OOO_DISP_W],
	input  ooo_pkg::funct3_t        disp_funct3_i [`OOO_DISP_W],
	input  ooo_pkg::funct7_t        disp_funct7_i [`OOO_DISP_W],
	input  ooo_pkg::preg_t          disp_ps1_i    [`OOO_DISP_W],
	input  ooo_pkg::preg_t          disp_ps2_i    [`OOO_DISP_W],
	input  ooo_pkg::preg_t          disp_pd_i     [`OOO_DISP_W],
	input  ooo_pkg::xlen_t          disp_instr_i  [`OOO_DISP_W],
	input  logic [`OOO_NUM_FU-1:0]  wb_valid_i,
	input  ooo_pkg::preg_t          wb_dest_i     [`OOO_NUM_FU],
	input  ooo_pkg::xlen_t          wb_data_i     [`OOO_NUM_FU],
	output logic                    disp_space_o,
	output logic [`OOO_NUM_FU-1:0]  res_valid_o,
	output ooo_pkg::xlen_t          res_data_o    [`OOO_NUM_FU],
	output ooo_pkg::preg_t          res_dest_o    [`OOO_NUM_FU],
	output ooo_pkg::pc_t            res_pc_o      [`OOO_NUM_FU]
);
	import ooo_pkg::*;

	logic [`OOO_DISP_W-1:0]    row_write;
	rs_idx_t                   row_wr_idx [`OOO_DISP_W];
	fu_t                       row_fu_tag [`OOO_DISP_W];
	logic [`OOO_DISP_W-1:0]    disp_is_store;

	logic [`OOO_RS_DEPTH-1:0]  row_in_use;
	logic [`OOO_RS_DEPTH-1:0]  row_ready;
	fu_t                       row_fu [`OOO_RS_DEPTH];

	logic [`OOO_NUM_FU-1:0]    issue;
	rs_idx_t                   issue_idx  [`OOO_NUM_FU];
	opcode_t                   iss_opcode [`OOO_NUM_FU];
	funct3_t                   iss_funct3 [`OOO_NUM_FU];
	funct7_t                   iss_funct7 [`OOO_NUM_FU];
	xlen_t                     iss_src1   [`OOO_NUM_FU];
	xlen_t                     iss_src2   [`OOO_NUM_FU];
	preg_t                     iss_dest   [`OOO_NUM_FU];
	pc_t                       iss_pc     [`OOO_NUM_FU];

	preg_t                     rd_reg   [2*`OOO_DISP_W];
	xlen_t                     rd_data  [2*`OOO_DISP_W];
	logic [2*`OOO_DISP_W-1:0]  rd_ready;

	// Two read ports per slot, src1 at the even index
	for (genvar s = 0; s < `OOO_DISP_W; s++) begin : g_rd
		assign rd_reg[2*s]      = disp_ps1_i[s];
		assign rd_reg[2*s + 1]  = disp_ps2_i[s];
		assign disp_is_store[s] = (disp_opcode_i[s] == `OP_STORE);
	end

	issue_ctrl u_ctrl (
		.clk_i, .rst_i, .disp_valid_i, .disp_opcode_i,
		.row_in_use_i(row_in_use), .row_ready_i(row_ready), .row_fu_i(row_fu),
		.row_write_o(row_write), .row_wr_idx_o(row_wr_idx), .row_fu_tag_o(row_fu_tag),
		.disp_space_o, .issue_o(issue), .issue_idx_o(issue_idx)
	);

	rs_array u_rs (
		.clk_i, .rst_i,
		.row_write_i(row_write), .row_wr_idx_i(row_wr_idx), .row_fu_tag_i(row_fu_tag),
		.disp_pc_i, .disp_opcode_i, .disp_funct3_i, .disp_funct7_i,
		.disp_ps1_i, .disp_ps2_i, .disp_pd_i, .disp_instr_i,
		.src_data_i(rd_data), .src_ready_i(rd_ready),
		.wb_valid_i, .wb_dest_i, .wb_data_i,
		.issue_i(issue), .issue_idx_i(issue_idx),
		.row_in_use_o(row_in_use), .row_ready_o(row_ready), .row_fu_o(row_fu),
		.iss_opcode_o(iss_opcode), .iss_funct3_o(iss_funct3), .iss_funct7_o(iss_funct7),
		.iss_src1_o(iss_src1), .iss_src2_o(iss_src2), .iss_dest_o(iss_dest), .iss_pc_o(iss_pc)
	);

	operand_file u_regs (
		.clk_i, .rst_i, .rd_reg_i(rd_reg),
		.disp_write_i(row_write), .disp_pd_i, .disp_is_store_i(disp_is_store),
		.wb_valid_i, .wb_dest_i, .wb_data_i,
		.rd_data_o(rd_data), .rd_ready_o(rd_ready)
	);

	for (genvar f = 0; f < `OOO_NUM_FU; f++) begin : g_fu
		exec_unit u_exec (
			.clk_i, .rst_i, .issue_i(issue[f]),
			.opcode_i(iss_opcode[f]), .funct3_i(iss_funct3[f]), .funct7_i(iss_funct7[f]),
			.src1_i(iss_src1[f]), .src2_i(iss_src2[f]), .dest_i(iss_dest[f]), .pc_i(iss_pc[f]),
			.res_valid_o(res_valid_o[f]), .res_data_o(res_data_o[f]),
			.res_dest_o(res_dest_o[f]), .res_pc_o(res_pc_o[f])
		);
	end

endmodule

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module exec_unit (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              issue_i,
	input  ooo_pkg::opcode_t  opcode_i,
	input  ooo_pkg::funct3_t  funct3_i,
	input  ooo_pkg::funct7_t  funct7_i,
	input  ooo_pkg::xlen_t    src1_i,
	input  ooo_pkg::xlen_t    src2_i,
	input  ooo_pkg::preg_t    dest_i,
	input  ooo_pkg::pc_t      pc_i,
	output logic              res_valid_o,
	output ooo_pkg::xlen_t    res_data_o,
	output ooo_pkg::preg_t    res_dest_o,
	output ooo_pkg::pc_t      res_pc_o
);
	import ooo_pkg::*;

	logic    issued_q;   // Operands below belong to an issued row
	opcode_t opcode_q;
	funct3_t funct3_q;
	funct7_t funct7_q;
	xlen_t   src1_q;
	xlen_t   src2_q;
	preg_t   dest_q;
	pc_t     pc_q;
	xlen_t   result;

	// Operands are taken at the issue edge
	always_ff @(posedge clk_i) begin
		if (rst_i)
			issued_q <= 1'b0;
		else
			issued_q <= issue_i;
		if (issue_i) begin
			opcode_q <= opcode_i;
			funct3_q <= funct3_i;
			funct7_q <= funct7_i;
			src1_q   <= src1_i;
			src2_q   <= src2_i;
			dest_q   <= dest_i;
			pc_q     <= pc_i;
		end
	end

	always_comb begin
		result = '0;
		case (opcode_q)
			`OP_REG:
				case (funct3_q)
					`F3_ADD: result = (funct7_q == `F7_SUB) ? src1_q - src2_q : src1_q + src2_q;
					`F3_XOR: result = src1_q ^ src2_q;
					`F3_SRA: result = xlen_t'($signed(src1_q) >>> src2_q[$clog2(`OOO_XLEN)-1:0]);
					default: result = '0;
				endcase
			`OP_IMM:
				if (funct3_q == `F3_AND)
					result = src1_q & src2_q;  // ANDI
				else
					result = src1_q + src2_q;  // ADDI
			`OP_LOAD, `OP_STORE: result = src1_q + src2_q;  // Effective address
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= issued_q;
		if (issued_q) begin
			res_data_o <= result;
			res_dest_o <= dest_q;
			res_pc_o   <= pc_q;
		end
	end

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_ctrl (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic [`OOO_DISP_W-1:0]    disp_valid_i,
	input  ooo_pkg::opcode_t          disp_opcode_i [`OOO_DISP_W],
	input  logic [`OOO_RS_DEPTH-1:0]  row_in_use_i,
	input  logic [`OOO_RS_DEPTH-1:0]  row_ready_i,
	input  ooo_pkg::fu_t              row_fu_i      [`OOO_RS_DEPTH],
	output logic [`OOO_DISP_W-1:0]    row_write_o,
	output ooo_pkg::rs_idx_t          row_wr_idx_o  [`OOO_DISP_W],
	output ooo_pkg::fu_t              row_fu_tag_o  [`OOO_DISP_W],
	output logic                      disp_space_o,
	output logic [`OOO_NUM_FU-1:0]    issue_o,
	output ooo_pkg::rs_idx_t          issue_idx_o   [`OOO_NUM_FU]
);
	import ooo_pkg::*;

	logic [`OOO_DISP_W-1:0] is_mem;
	logic [`OOO_DISP_W-1:0] is_known;
	logic [`OOO_DISP_W-1:0] alu_wr;
	logic                   alu_sel_q;   // ALU that gets the next ALU instruction
	logic                   alu_sel_nxt;

	// Lowest free rows, one per slot
	always_comb begin
		int unsigned n;
		n = 0;
		for (int s = 0; s < `OOO_DISP_W; s++)
			row_wr_idx_o[s] = '0;
		for (int r = 0; r < `OOO_RS_DEPTH; r++) begin
			if (!row_in_use_i[r] && n < `OOO_DISP_W) begin
				row_wr_idx_o[n] = rs_idx_t'(r);
				n++;
			end
		end
		disp_space_o = (n == `OOO_DISP_W);
	end

	// Write strobes and FU routing, slot 0 takes the toggle first
	always_comb begin
		logic sel;
		sel = alu_sel_q;
		for (int s = 0; s < `OOO_DISP_W; s++) begin
			is_mem[s]   = (disp_opcode_i[s] == `OP_LOAD) || (disp_opcode_i[s] == `OP_STORE);
			is_known[s] = is_mem[s] || (disp_opcode_i[s] == `OP_IMM) ||
			              (disp_opcode_i[s] == `OP_REG);
			row_write_o[s] = disp_valid_i[s] && is_known[s] && disp_space_o;
			alu_wr[s] = row_write_o[s] && !is_mem[s];
			row_fu_tag_o[s] = is_mem[s] ? fu_t'(`MEM_FU) : fu_t'(sel);
			if (alu_wr[s])
				sel = ~sel;
		end
		alu_sel_nxt = sel;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			alu_sel_q <= 1'b0;
		else
			alu_sel_q <= alu_sel_nxt;
	end

	// Per FU pick, the downward scan leaves the lowest matching row
	always_comb begin
		for (int f = 0; f < `OOO_NUM_FU; f++) begin
			issue_o[f]     = 1'b0;
			issue_idx_o[f] = '0;
			for (int r = `OOO_RS_DEPTH - 1; r >= 0; r--) begin
				if (row_in_use_i[r] && row_ready_i[r] && row_fu_i[r] == fu_t'(f)) begin
					issue_o[f]     = 1'b1;
					issue_idx_o[f] = rs_idx_t'(r);
				end
			end
		end
	end

	// Upstream has to hold off while fewer than two rows are free
	a_disp_needs_space: assert property (@(posedge clk_i) disable iff (rst_i)
		(|disp_valid_i) |-> disp_space_o)
		else $error("dispatch strobe while disp_space_o is low");

endmodule

// ==== hdl/ooo_params.svh ====
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Datapath and structure sizes
`define OOO_XLEN      32
`define OOO_PREGS     64
`define OOO_RS_DEPTH  16
`define OOO_DISP_W    2
`define OOO_NUM_FU    3    // Also the number of writeback ports
`define OOO_PC_W      7

// RV32 major opcodes handled by the stage
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// func3 / func7 codes of the supported ALU operations
`define F3_ADD  3'b000
`define F3_XOR  3'b100
`define F3_SRA  3'b101
`define F3_AND  3'b111
`define F7_SUB  7'b0100000

`define MEM_FU  2          // Loads and stores only

`endif

// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

`include "ooo_params.svh"

	typedef logic [`OOO_XLEN-1:0]             xlen_t;
	typedef logic [$clog2(`OOO_PREGS)-1:0]    preg_t;
	typedef logic [$clog2(`OOO_RS_DEPTH)-1:0] rs_idx_t;
	typedef logic [`OOO_PC_W-1:0]             pc_t;
	typedef logic [1:0]                       fu_t;
	typedef logic [6:0]                       opcode_t;
	typedef logic [2:0]                       funct3_t;
	typedef logic [6:0]                       funct7_t;

	// One reservation station row
	typedef struct packed {
		logic    in_use;
		pc_t     pc;
		opcode_t opcode;
		funct3_t funct3;
		funct7_t funct7;
		preg_t   dest;

		preg_t   src1_reg;
		xlen_t   src1_data;
		logic    src1_rdy;

		// Holds the immediate for I and S formats, then src2_rdy is set
		preg_t   src2_reg;
		xlen_t   src2_data;
		logic    src2_rdy;

		// Store data register, only waited on and never read here
		preg_t   sw_reg;
		logic    sw_rdy;

		fu_t     fu;          // FU this row is routed to
	} rs_row_t;

endpackage

// ==== hdl/operand_file.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module operand_file (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  ooo_pkg::preg_t            rd_reg_i        [2*`OOO_DISP_W],
	input  logic [`OOO_DISP_W-1:0]    disp_write_i,
	input  ooo_pkg::preg_t            disp_pd_i       [`OOO_DISP_W],
	input  logic [`OOO_DISP_W-1:0]    disp_is_store_i,
	input  logic [`OOO_NUM_FU-1:0]    wb_valid_i,
	input  ooo_pkg::preg_t            wb_dest_i       [`OOO_NUM_FU],
	input  ooo_pkg::xlen_t            wb_data_i       [`OOO_NUM_FU],
	output ooo_pkg::xlen_t            rd_data_o       [2*`OOO_DISP_W],
	output logic [2*`OOO_DISP_W-1:0]  rd_ready_o
);
	import ooo_pkg::*;

	xlen_t                  regs_q [`OOO_PREGS];
	logic [`OOO_PREGS-1:0]  ready_q;
	logic [`OOO_DISP_W-1:0] claims;   // Slot makes its destination busy

	always_comb begin
		for (int s = 0; s < `OOO_DISP_W; s++)
			claims[s] = disp_write_i[s] && !disp_is_store_i[s] && disp_pd_i[s] != '0;
	end

	always_comb begin
		for (int p = 0; p < 2*`OOO_DISP_W; p++) begin
			rd_data_o[p]  = regs_q[rd_reg_i[p]];
			rd_ready_o[p] = ready_q[rd_reg_i[p]];
			for (int w = 0; w < `OOO_NUM_FU; w++) begin
				if (wb_valid_i[w] && wb_dest_i[w] == rd_reg_i[p]) begin
					rd_data_o[p]  = wb_data_i[w];
					rd_ready_o[p] = 1'b1;
				end
			end
			// An earlier slot of the same pair produces this source
			for (int s = 0; s < p / 2; s++)
				if (claims[s] && disp_pd_i[s] == rd_reg_i[p])
					rd_ready_o[p] = 1'b0;
			if (rd_reg_i[p] == '0) begin
				rd_data_o[p]  = '0;
				rd_ready_o[p] = 1'b1;
			end
		end
	end

	// Writebacks come last so they win over a same-edge claim
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int r = 0; r < `OOO_PREGS; r++)
				regs_q[r] <= '0;
			ready_q <= '1;
		end else begin
			for (int s = 0; s < `OOO_DISP_W; s++)
				if (claims[s])
					ready_q[disp_pd_i[s]] <= 1'b0;
			for (int w = 0; w < `OOO_NUM_FU; w++) begin
				if (wb_valid_i[w] && wb_dest_i[w] != '0) begin
					regs_q[wb_dest_i[w]]  <= wb_data_i[w];
					ready_q[wb_dest_i[w]] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/rs_array.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module rs_array (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [`OOO_DISP_W-1:0]      row_write_i,
	input  ooo_pkg::rs_idx_t            row_wr_idx_i  [`OOO_DISP_W],
	input  ooo_pkg::fu_t                row_fu_tag_i  [`OOO_DISP_W],
	input  ooo_pkg::pc_t                disp_pc_i     [`OOO_DISP_W],
	input  ooo_pkg::opcode_t            disp_opcode_i [`OOO_DISP_W],
	input  ooo_pkg::funct3_t            disp_funct3_i [`OOO_DISP_W],
	input  ooo_pkg::funct7_t            disp_funct7_i [`OOO_DISP_W],
	input  ooo_pkg::preg_t              disp_ps1_i    [`OOO_DISP_W],
	input  ooo_pkg::preg_t              disp_ps2_i    [`OOO_DISP_W],
	input  ooo_pkg::preg_t              disp_pd_i     [`OOO_DISP_W],
	input  ooo_pkg::xlen_t              disp_instr_i  [`OOO_DISP_W],
	input  ooo_pkg::xlen_t              src_data_i    [2*`OOO_DISP_W],
	input  logic [2*`OOO_DISP_W-1:0]    src_ready_i,
	input  logic [`OOO_NUM_FU-1:0]      wb_valid_i,
	input  ooo_pkg::preg_t              wb_dest_i     [`OOO_NUM_FU],
	input  ooo_pkg::xlen_t              wb_data_i     [`OOO_NUM_FU],
	input  logic [`OOO_NUM_FU-1:0]      issue_i,
	input  ooo_pkg::rs_idx_t            issue_idx_i   [`OOO_NUM_FU],
	output logic [`OOO_RS_DEPTH-1:0]    row_in_use_o,
	output logic [`OOO_RS_DEPTH-1:0]    row_ready_o,
	output ooo_pkg::fu_t                row_fu_o      [`OOO_RS_DEPTH],
	output ooo_pkg::opcode_t            iss_opcode_o  [`OOO_NUM_FU],
	output ooo_pkg::funct3_t            iss_funct3_o  [`OOO_NUM_FU],
	output ooo_pkg::funct7_t            iss_funct7_o  [`OOO_NUM_FU],
	output ooo_pkg::xlen_t              iss_src1_o    [`OOO_NUM_FU],
	output ooo_pkg::xlen_t              iss_src2_o    [`OOO_NUM_FU],
	output ooo_pkg::preg_t              iss_dest_o    [`OOO_NUM_FU],
	output ooo_pkg::pc_t                iss_pc_o      [`OOO_NUM_FU]
);
	import ooo_pkg::*;

	rs_row_t rows     [`OOO_RS_DEPTH];
	rs_row_t row_nxt  [`OOO_RS_DEPTH];   // After wakeup and issue clear
	rs_row_t new_row  [`OOO_DISP_W];

	// Rows built from the dispatch slots
	always_comb begin
		for (int s = 0; s < `OOO_DISP_W; s++) begin
			new_row[s].in_use    = 1'b1;
			new_row[s].pc        = disp_pc_i[s];
			new_row[s].opcode    = disp_opcode_i[s];
			new_row[s].funct3    = disp_funct3_i[s];
			new_row[s].funct7    = disp_funct7_i[s];
			new_row[s].dest      = disp_pd_i[s];
			new_row[s].fu        = row_fu_tag_i[s];
			new_row[s].src1_reg  = disp_ps1_i[s];
			new_row[s].src1_data = src_data_i[2*s];
			new_row[s].src1_rdy  = src_ready_i[2*s];
			new_row[s].src2_reg  = '0;
			new_row[s].src2_rdy  = 1'b1;
			new_row[s].sw_reg    = '0;
			new_row[s].sw_rdy    = 1'b1;
			case (disp_opcode_i[s])
				`OP_REG: begin
					new_row[s].src2_reg  = disp_ps2_i[s];
					new_row[s].src2_data = src_data_i[2*s + 1];
					new_row[s].src2_rdy  = src_ready_i[2*s + 1];
				end
				`OP_STORE: begin      // S-type immediate, rs2 is the data register
					new_row[s].src2_data = xlen_t'($signed({disp_instr_i[s][31:25],
					                                        disp_instr_i[s][11:7]}));
					new_row[s].sw_reg    = disp_ps2_i[s];
					new_row[s].sw_rdy    = src_ready_i[2*s + 1];
				end
				default:              // ADDI, ANDI and LW
					new_row[s].src2_data = xlen_t'($signed(disp_instr_i[s][31:20]));
			endcase
		end
	end

	always_comb begin
		for (int r = 0; r < `OOO_RS_DEPTH; r++) begin
			row_nxt[r] = rows[r];
			for (int w = 0; w < `OOO_NUM_FU; w++) begin
				if (wb_valid_i[w] && wb_dest_i[w] != '0) begin
					if (!rows[r].src1_rdy && rows[r].src1_reg == wb_dest_i[w]) begin
						row_nxt[r].src1_data = wb_data_i[w];
						row_nxt[r].src1_rdy  = 1'b1;
					end
					if (!rows[r].src2_rdy && rows[r].src2_reg == wb_dest_i[w]) begin
						row_nxt[r].src2_data = wb_data_i[w];
						row_nxt[r].src2_rdy  = 1'b1;
					end
					if (rows[r].sw_reg == wb_dest_i[w])
						row_nxt[r].sw_rdy = 1'b1;
				end
			end
			for (int f = 0; f < `OOO_NUM_FU; f++)
				if (issue_i[f] && issue_idx_i[f] == rs_idx_t'(r))
					row_nxt[r].in_use = 1'b0;
		end
	end

	// Dispatch only targets free rows, so it never collides with an issue clear
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int r = 0; r < `OOO_RS_DEPTH; r++)
				rows[r].in_use <= 1'b0;
		end else begin
			for (int r = 0; r < `OOO_RS_DEPTH; r++)
				rows[r] <= row_nxt[r];
			for (int s = 0; s < `OOO_DISP_W; s++)
				if (row_write_i[s])
					rows[row_wr_idx_i[s]] <= new_row[s];
		end
	end

	always_comb begin
		for (int r = 0; r < `OOO_RS_DEPTH; r++) begin
			row_in_use_o[r] = rows[r].in_use;
			row_ready_o[r]  = rows[r].src1_rdy && rows[r].src2_rdy && rows[r].sw_rdy;
			row_fu_o[r]     = rows[r].fu;
		end
	end

	always_comb begin
		rs_row_t sel;
		for (int f = 0; f < `OOO_NUM_FU; f++) begin
			sel = rows[issue_idx_i[f]];
			iss_opcode_o[f] = sel.opcode;
			iss_funct3_o[f] = sel.funct3;
			iss_funct7_o[f] = sel.funct7;
			iss_src1_o[f]   = sel.src1_data;
			iss_src2_o[f]   = sel.src2_data;
			iss_dest_o[f]   = (sel.opcode == `OP_STORE) ? sel.sw_reg : sel.dest;
			iss_pc_o[f]     = sel.pc;
		end
	end

	for (genvar f = 0; f < `OOO_NUM_FU; f++) begin : g_chk
		a_issue_ready: assert property (@(posedge clk_i) disable iff (rst_i)
			issue_i[f] |-> row_in_use_o[issue_idx_i[f]] && row_ready_o[issue_idx_i[f]])
			else $error("FU %0d issued a row that is empty or waiting", f);
	end

endmodule

// ==== sim/tb_dispatch.sv ====
`timescale 1ns/1ps
`include "ooo_params.svh"

module tb_dispatch;
	import ooo_pkg::*;

	localparam int    NUM_INSTR   = 120;                    // Fits the 7-bit pc tags
	localparam int    CYCLE_LIMIT = 40 * NUM_INSTR + 100;
	localparam int    NUM_PC      = 2 ** `OOO_PC_W;
	localparam xlen_t LW_KEY      = 32'h5a5a_0f0f;          // Load data is address XOR this

	logic                   clk_i = 1'b0;
	logic                   rst_i;
	logic [`OOO_DISP_W-1:0] disp_valid;
	pc_t                    disp_pc     [`OOO_DISP_W];
	opcode_t                disp_opcode [`OOO_DISP_W];
	funct3_t                disp_funct3 [`OOO_DISP_W];
	funct7_t                disp_funct7 [`OOO_DISP_W];
	preg_t                  disp_ps1    [`OOO_DISP_W];
	preg_t                  disp_ps2    [`OOO_DISP_W];
	preg_t                  disp_pd     [`OOO_DISP_W];
	xlen_t                  disp_instr  [`OOO_DISP_W];
	logic [`OOO_NUM_FU-1:0] wb_valid;
	preg_t                  wb_dest     [`OOO_NUM_FU];
	xlen_t                  wb_data     [`OOO_NUM_FU];
	logic                   disp_space;
	logic [`OOO_NUM_FU-1:0] res_valid;
	xlen_t                  res_data    [`OOO_NUM_FU];
	preg_t                  res_dest    [`OOO_NUM_FU];
	pc_t                    res_pc      [`OOO_NUM_FU];

	// Model state, mval is the value a register holds once its producer writes back
	xlen_t mval [`OOO_PREGS];
	logic  busy [`OOO_PREGS];
	int    prod [`OOO_PREGS];       // Pc of the pending producer
	logic  pend      [NUM_PC];
	logic  wb_done   [NUM_PC];
	logic  exp_store [NUM_PC];
	xlen_t exp_data  [NUM_PC];
	xlen_t exp_wb    [NUM_PC];
	preg_t exp_dest  [NUM_PC];
	fu_t   exp_fu    [NUM_PC];
	int    dep1      [NUM_PC];
	int    dep2      [NUM_PC];

	integer seed;
	int     next_pc, pend_cnt, known_cnt, result_cnt;
	int     checks, errors, cycles, tests_run, tests_failed, test_err0;
	logic   alu_turn;
	logic   pair_claim;             // Slot 0 took a destination this cycle
	preg_t  pair_pd;

	always #5 clk_i = ~clk_i;

	dispatch_top UUT (
		.clk_i(clk_i), .rst_i(rst_i), .disp_valid_i(disp_valid),
		.disp_pc_i(disp_pc), .disp_opcode_i(disp_opcode), .disp_funct3_i(disp_funct3),
		.disp_funct7_i(disp_funct7), .disp_ps1_i(disp_ps1), .disp_ps2_i(disp_ps2),
		.disp_pd_i(disp_pd), .disp_instr_i(disp_instr),
		.wb_valid_i(wb_valid), .wb_dest_i(wb_dest), .wb_data_i(wb_data),
		.disp_space_o(disp_space), .res_valid_o(res_valid), .res_data_o(res_data),
		.res_dest_o(res_dest), .res_pc_o(res_pc)
	);

	task automatic check_data(input string what, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s data %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input string what, input preg_t got, input preg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s dest p%0d, expected p%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_fu(input string what, input fu_t got, input fu_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s on FU %0d, expected FU %0d", $time, what, got, exp);
		end
	endtask

	task automatic begin_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - test_err0);
		end
	endtask

	// Fills one slot with a random instruction and predicts its result
	task automatic dispatch_slot(input int s);
		int      kind;
		int      pc;
		xlen_t   ins;
		xlen_t   a;
		xlen_t   b;
		xlen_t   res;
		preg_t   ps1;
		preg_t   ps2;
		preg_t   pd;
		opcode_t op;
		funct3_t f3;
		funct7_t f7;
		kind = {$random(seed)} % 16;
		ins  = $random(seed);
		ps1  = preg_t'({$random(seed)} % 32);
		ps2  = preg_t'({$random(seed)} % 32);
		if (s == 1 && pair_claim && {$random(seed)} % 3 == 0)
			ps1 = pair_pd;                  // Same-pair dependency
		do
			pd = preg_t'(1 + {$random(seed)} % 31);
		while (busy[pd]);
		f7 = '0;
		case (kind)
			0:          begin op = 7'b1111111; f3 = 3'b000; end
			1, 2:       begin op = `OP_REG;   f3 = `F3_ADD; end
			3:          begin op = `OP_REG;   f3 = `F3_ADD; f7 = `F7_SUB; end
			4, 5:       begin op = `OP_REG;   f3 = `F3_XOR; end
			6:          begin op = `OP_REG;   f3 = `F3_SRA; f7 = `F7_SUB; end
			7, 8:       begin op = `OP_IMM;   f3 = `F3_ADD; end
			9:          begin op = `OP_IMM;   f3 = `F3_AND; end
			10, 11, 12: begin op = `OP_LOAD;  f3 = 3'b010; end
			default:    begin op = `OP_STORE; f3 = 3'b010; end
		endcase
		ins[6:0]   = op;
		ins[14:12] = f3;
		if (op == `OP_REG)
			ins[31:25] = f7;
		pc = next_pc;
		next_pc++;
		disp_valid[s]  = 1'b1;
		disp_pc[s]     = pc_t'(pc);
		disp_opcode[s] = op;
		disp_funct3[s] = f3;
		disp_funct7[s] = f7;
		disp_ps1[s]    = ps1;
		disp_ps2[s]    = ps2;
		disp_pd[s]     = pd;
		disp_instr[s]  = ins;
		if (kind == 0)
			return;                         // Dropped by the stage
		a = mval[ps1];
		b = mval[ps2];
		case (kind)
			1, 2:              res = a + b;
			3:                 res = a - b;
			4, 5:              res = a ^ b;
			6:                 res = xlen_t'($signed(a) >>> b[4:0]);
			7, 8, 10, 11, 12:  res = a + {{20{ins[31]}}, ins[31:20]};
			9:                 res = a & {{20{ins[31]}}, ins[31:20]};
			default:           res = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
		endcase
		pend[pc]      = 1'b1;
		wb_done[pc]   = 1'b0;
		pend_cnt++;
		known_cnt++;
		exp_store[pc] = (op == `OP_STORE);
		exp_data[pc]  = res;
		exp_wb[pc]    = (op == `OP_LOAD) ? res ^ LW_KEY : res;
		exp_dest[pc]  = exp_store[pc] ? ps2 : pd;
		dep1[pc]      = busy[ps1] ? prod[ps1] : -1;
		dep2[pc]      = ((op == `OP_REG || exp_store[pc]) && busy[ps2]) ? prod[ps2] : -1;
		if (op == `OP_LOAD || exp_store[pc]) begin
			exp_fu[pc] = fu_t'(`MEM_FU);
		end else begin
			exp_fu[pc] = fu_t'(alu_turn);
			alu_turn   = ~alu_turn;
		end
		if (!exp_store[pc]) begin
			busy[pd]   = 1'b1;
			prod[pd]   = pc;
			mval[pd]   = exp_wb[pc];
			pair_claim = 1'b1;
			pair_pd    = pd;
		end
	endtask

	// Checks this cycle's results, then writes them back on the matching port
	task automatic collect_results();
		int    pc;
		int    wb_pc [`OOO_NUM_FU];
		string tag;
		for (int f = 0; f < `OOO_NUM_FU; f++)
			if (wb_valid[f])
				busy[wb_dest[f]] = 1'b0;        // That writeback landed at the last edge
		for (int f = 0; f < `OOO_NUM_FU; f++) begin
			wb_pc[f] = -1;
			if (res_valid[f]) begin
				pc = res_pc[f];
				result_cnt++;
				if (!pend[pc]) begin
					errors++;
					$display("FU %0d gave a result for pc %0d, which has none outstanding", f, pc);
				end else begin
					tag = $sformatf("FU %0d pc %0d", f, pc);
					check_data(tag, res_data[f], exp_data[pc]);
					check_reg(tag, res_dest[f], exp_dest[pc]);
					check_fu(tag, fu_t'(f), exp_fu[pc]);
					checks++;
					if ((dep1[pc] >= 0 && !wb_done[dep1[pc]]) ||
					    (dep2[pc] >= 0 && !wb_done[dep2[pc]])) begin
						errors++;
						$display("pc %0d finished before a source it waits for was written back", pc);
					end
					pend[pc] = 1'b0;
					pend_cnt--;
					if (!exp_store[pc])
						wb_pc[f] = pc;
				end
			end
		end
		for (int f = 0; f < `OOO_NUM_FU; f++) begin
			wb_valid[f] = (wb_pc[f] >= 0);
			if (wb_pc[f] >= 0) begin
				wb_dest[f] = exp_dest[wb_pc[f]];
				wb_data[f] = exp_wb[wb_pc[f]];
				wb_done[wb_pc[f]] = 1'b1;
			end
		end
	endtask

	task automatic run_cycle(input logic allow_disp);
		@(negedge clk_i);
		collect_results();
		disp_valid = '0;
		pair_claim = 1'b0;
		if (allow_disp && disp_space)
			for (int s = 0; s < `OOO_DISP_W; s++)
				if (next_pc < NUM_INSTR && {$random(seed)} % 4 != 0)
					dispatch_slot(s);
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("timeout: %0d results still outstanding after %0d cycles", pend_cnt, cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed = 90;
		rst_i = 1'b1;
		disp_valid = '0;
		wb_valid = '0;
		for (int s = 0; s < `OOO_DISP_W; s++) begin
			disp_pc[s]     = '0;
			disp_opcode[s] = '0;
			disp_funct3[s] = '0;
			disp_funct7[s] = '0;
			disp_ps1[s]    = '0;
			disp_ps2[s]    = '0;
			disp_pd[s]     = '0;
			disp_instr[s]  = '0;
		end
		for (int f = 0; f < `OOO_NUM_FU; f++) begin
			wb_dest[f] = '0;
			wb_data[f] = '0;
		end
		for (int r = 0; r < `OOO_PREGS; r++) begin
			mval[r] = '0;
			busy[r] = 1'b0;
			prod[r] = -1;
		end
		for (int p = 0; p < NUM_PC; p++) begin
			pend[p]    = 1'b0;
			wb_done[p] = 1'b0;
		end
		{next_pc, pend_cnt, known_cnt, result_cnt} = '0;
		{checks, errors, tests_run, tests_failed} = '0;
		alu_turn   = 1'b0;
		pair_claim = 1'b0;
		pair_pd    = '0;
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		begin_test();
		@(negedge clk_i);
		checks += 2;
		if (res_valid !== '0) begin
			errors++;
			$display("a result was valid right after reset");
		end
		if (disp_space !== 1'b1) begin
			errors++;
			$display("disp_space_o was not high right after reset");
		end
		end_test("reset state");

		begin_test();
		while (next_pc < NUM_INSTR)
			run_cycle(1'b1);
		end_test("random dispatch");

		begin_test();
		while (pend_cnt != 0 || wb_valid != '0)
			run_cycle(1'b0);
		repeat (5) run_cycle(1'b0);         // A stray late result would show up here
		checks++;
		if (result_cnt != known_cnt) begin
			errors++;
			$display("%0d results seen for %0d stored instructions", result_cnt, known_cnt);
		end
		end_test("drain");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, instructions %0d, results %0d",
		         tests_run, tests_failed, checks, errors, next_pc, result_cnt);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
